//--- vlog.f
+incdir+.
rvPkg.sv
RegisterFile.sv
Alu.sv
ImmExtend.sv
ControlUnit.sv
DataPath.sv
RvCore.sv
tbRvCore.sv

//--- Makefile
TOP := tbRvCore

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f vlog.f -o simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir

//--- rvModel.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural state of the instruction-set model.
logic [31:0] modelRegs [32];
logic [31:0] modelMem [64];
logic [31:0] modelPc;

// Bus activity of the last stepped instruction.
logic        expWe;
logic [31:0] expAddr;
logic [31:0] expWData;

function automatic logic [31:0] readReg(input logic [4:0] idx);
    return (idx == 5'd0) ? 32'd0 : modelRegs[idx]; // x0 is hardwired.
endfunction

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = 32'(i);
    end
    modelPc = 32'd0;
endtask

task automatic stepModel(input logic [31:0] instr);
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immJ;
    logic [31:0] opB;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic        wr;
    src1     = readReg(instr[19:15]);
    src2     = readReg(instr[24:20]);
    immI     = {{20{instr[31]}}, instr[31:20]};
    immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    immJ     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    opB      = (instr[6:0] == OP_TYPE_R) ? src2 : immI;
    addr     = 32'd0;
    res      = 32'd0;
    wr       = 1'b0;
    nextPc   = modelPc + 32'd4;
    expWe    = 1'b0;
    expAddr  = 32'd0;
    expWData = 32'd0;
    case (instr[6:0])
        OP_TYPE_R, OP_TYPE_I: begin
            wr = 1'b1;
            case (instr[14:12])
                3'd0: res = (instr[6:0] == OP_TYPE_R && instr[30]) ? src1 - opB : src1 + opB;
                3'd1: res = src1 << opB[4:0];
                3'd2: res = ($signed(src1) < $signed(opB)) ? 32'd1 : 32'd0;
                3'd3: res = (src1 < opB) ? 32'd1 : 32'd0;
                3'd4: res = src1 ^ opB;
                3'd5: begin
                    if (instr[30]) begin
                        res = $signed(src1) >>> opB[4:0]; // Sign bit fills from the left.
                    end else begin
                        res = src1 >> opB[4:0];
                    end
                end
                3'd6: res = src1 | opB;
                default: res = src1 & opB;
            endcase
        end
        OP_TYPE_I_LOAD: begin
            wr   = 1'b1;
            addr = src1 + immI;
            res  = modelMem[addr[7:2]];
        end
        OP_TYPE_S: begin
            addr     = src1 + immS;
            expWe    = 1'b1;
            expAddr  = addr;
            expWData = src2;
            modelMem[addr[7:2]] = src2;
        end
        OP_TYPE_U_LUI: begin
            wr  = 1'b1;
            res = {instr[31:12], 12'd0};
        end
        OP_TYPE_J_JAL: begin
            wr     = 1'b1;
            res    = modelPc + 32'd4; // Link address.
            nextPc = modelPc + immJ;
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    if (wr && instr[11:7] != 5'd0) begin
        modelRegs[instr[11:7]] = res;
    end
    modelPc = nextPc;
endtask

`endif

//--- tbRvCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbRvCore import rvPkg::*; ();

    localparam int clkPeriod  = 40;
    localparam int randCount  = 200;
    localparam int progLen    = randCount + 32; // Random part, register sweep, halt loop.
    localparam int watchdogNs = (progLen + 40) * clkPeriod * 2;
    localparam logic [31:0] haltAddr = 32'((progLen - 1) * 4);
    // R-type operations as {funct7[5], funct3}.
    localparam logic [3:0] rOps [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                         4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

    logic        clk;
    logic        reset;
    logic [31:0] instrCode;
    logic [31:0] instrMemAddr;
    logic [31:0] busAddr;
    logic [31:0] busWData;
    logic        busWe;
    logic [31:0] busRData;
    logic [31:0] rom [progLen];
    logic [31:0] dataMem [64];
    logic [31:0] rngState;
    int          errors;
    int          cycles;
    int          haltCycles;

    `include "rvModel.svh"

    RvCore #(
        .resetPc(32'd0),
        .numRegs(32)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .instrCode   (instrCode),
        .instrMemAddr(instrMemAddr),
        .busAddr     (busAddr),
        .busWData    (busWData),
        .busWe       (busWe),
        .busRData    (busRData)
    );

    // Combinational instruction and data reads.
    assign instrCode = (instrMemAddr < 32'(progLen * 4)) ? rom[instrMemAddr[9:2]] : 32'h0000_0013;
    assign busRData  = dataMem[busAddr[7:2]];

    always @(posedge clk) begin
        if (busWe) begin
            dataMem[busAddr[7:2]] <= busWData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic logic [31:0] rTypeInstr(input logic [3:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rd, OP_TYPE_R};
    endfunction

    function automatic logic [31:0] iTypeInstr(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sTypeInstr(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_TYPE_S};
    endfunction

    function automatic logic [31:0] jTypeInstr(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_TYPE_J_JAL};
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] f;
        logic [11:0] imm;
        int          k;
        for (int i = 0; i < randCount; i++) begin
            r   = nextRandom();
            f   = nextRandom();
            imm = {4'b0, f[27:22], 2'b00}; // Word-aligned, 0 to 252.
            if (r[3:0] < 4'd5) begin
                rom[i] = rTypeInstr(rOps[int'(r[11:4]) % 10], f[4:0], f[9:5], f[14:10]);
            end else if (r[3:0] < 4'd10) begin
                if (r[6:4] == 3'd1) begin
                    imm = {7'b0, f[24:20]};
                end else if (r[6:4] == 3'd5) begin
                    imm = {1'b0, r[7], 5'b0, f[24:20]}; // SRLI or SRAI.
                end else begin
                    imm = f[31:20];
                end
                rom[i] = iTypeInstr(imm, f[9:5], r[6:4], f[4:0], OP_TYPE_I);
            end else if (r[3:0] < 4'd12) begin
                rom[i] = iTypeInstr(imm, 5'd0, 3'b010, f[4:0], OP_TYPE_I_LOAD);
            end else if (r[3:0] < 4'd14) begin
                rom[i] = sTypeInstr(imm, f[14:10], 5'd0);
            end else if (r[3:0] == 4'd14) begin
                rom[i] = {f[31:12], f[4:0], OP_TYPE_U_LUI};
            end else begin
                k = 1 + int'(r[6:4]);
                if (i + k > randCount) begin
                    k = randCount - i; // Stay inside the random part.
                end
                rom[i] = jTypeInstr(21'(k * 4), f[4:0]);
            end
        end
        // The reset address holds a store, so busWe must be held low during reset.
        rom[0] = sTypeInstr(12'd16, 5'd7, 5'd0);
        for (int i = 1; i < 32; i++) begin
            rom[randCount + i - 1] = sTypeInstr(12'(i * 4), 5'(i), 5'd0);
        end
        rom[progLen - 1] = jTypeInstr(21'd0, 5'd0);
    endtask

    task automatic seedMemory();
        logic [31:0] value;
        for (int i = 0; i < 64; i++) begin
            value = nextRandom();
            dataMem[i] <= value;
            modelMem[i] = value;
        end
    endtask

    task automatic reportWord(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic [31:0] pc);
        errors++;
        $display("[FAIL] %s: got %h, expected %h at pc %h", name, got, exp, pc);
    endtask

    initial begin
        logic [31:0] instr;
        logic [31:0] pc;
        errors     = 0;
        cycles     = 0;
        haltCycles = 0;
        rngState   = 32'hb20a_8b63;
        reset <= 1'b1;
        buildProgram();
        seedMemory();
        resetModel();
        repeat (4) begin
            @(negedge clk);
            if (busWe !== 1'b0) begin
                errors++;
                $display("busWe was high while reset was asserted");
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        while (haltCycles < 3) begin
            @(negedge clk);
            cycles++;
            pc = modelPc;
            if (instrMemAddr !== pc) begin
                reportWord("instrMemAddr", instrMemAddr, pc, pc);
            end
            if (pc == haltAddr) begin
                haltCycles++;
            end
            instr = rom[pc[9:2]];
            stepModel(instr);
            if (busWe !== expWe) begin
                reportWord("busWe", 32'(busWe), 32'(expWe), pc);
            end
            if (expWe && busAddr !== expAddr) begin
                reportWord("busAddr", busAddr, expAddr, pc);
            end
            if (expWe && busWData !== expWData) begin
                reportWord("busWData", busWData, expWData, pc);
            end
        end
        $display("cycles checked: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the core did not reach the halt loop within %0d ns", watchdogNs);
        $display("cycles checked: %0d, errors: %0d", cycles, errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- RvCore.sv
`timescale 1ns/1ps
`default_nettype none

module RvCore import rvPkg::*; #(
    parameter logic [XLEN-1:0] resetPc = '0,
    parameter int              numRegs = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] instrCode,
    output logic [XLEN-1:0] instrMemAddr,
    output logic [XLEN-1:0] busAddr,
    output logic [XLEN-1:0] busWData,
    output logic            busWe,
    input  logic [XLEN-1:0] busRData
);
    logic regFileWe;
    logic aluSrcMuxSel;
    aluOp aluControl;
    wbSel memToRegSel;
    pcSel nextPcSel;

    ControlUnit controlUnit0 (
        .reset       (reset),
        .instrCode   (instrCode),
        .regFileWe   (regFileWe),
        .aluSrcMuxSel(aluSrcMuxSel),
        .aluControl  (aluControl),
        .memToRegSel (memToRegSel),
        .nextPcSel   (nextPcSel),
        .busWe       (busWe)
    );

    DataPath #(
        .resetPc(resetPc),
        .numRegs(numRegs)
    ) dataPath0 (
        .clk         (clk),
        .reset       (reset),
        .instrCode   (instrCode),
        .regFileWe   (regFileWe),
        .aluSrcMuxSel(aluSrcMuxSel),
        .aluControl  (aluControl),
        .memToRegSel (memToRegSel),
        .nextPcSel   (nextPcSel),
        .instrMemAddr(instrMemAddr),
        .busAddr     (busAddr),
        .busWData    (busWData),
        .busRData    (busRData)
    );

endmodule

`default_nettype wire

//--- DataPath.sv
`timescale 1ns/1ps
`default_nettype none

module DataPath import rvPkg::*; #(
    parameter logic [XLEN-1:0] resetPc = '0,
    parameter int              numRegs = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] instrCode,
    input  logic            regFileWe,
    input  logic            aluSrcMuxSel,
    input  aluOp            aluControl,
    input  wbSel            memToRegSel,
    input  pcSel            nextPcSel,
    output logic [XLEN-1:0] instrMemAddr,
    output logic [XLEN-1:0] busAddr,
    output logic [XLEN-1:0] busWData,
    input  logic [XLEN-1:0] busRData
);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcJump;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] rfData1;
    logic [XLEN-1:0] rfData2;
    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] aluSrcB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] wbData;

    assign pcPlus4 = pc + XLEN'(4);
    assign pcJump  = pc + immExt; // JAL target.

    always_comb begin
        case (nextPcSel)
            PC_JUMP: nextPc = pcJump;
            default: nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    assign aluSrcB = aluSrcMuxSel ? immExt : rfData2;

    // Write-back source.
    always_comb begin
        case (memToRegSel)
            WB_ALU:  wbData = aluResult;
            WB_LOAD: wbData = busRData;
            WB_PC4:  wbData = pcPlus4;  // Link address for JAL.
            WB_IMM:  wbData = immExt;   // LUI.
            default: wbData = aluResult;
        endcase
    end

    assign instrMemAddr = pc;
    assign busAddr      = aluResult;
    assign busWData     = rfData2;

    RegisterFile #(
        .numRegs(numRegs)
    ) regFile0 (
        .clk      (clk),
        .we       (regFileWe),
        .readAddr1(instrCode[19:15]),
        .readAddr2(instrCode[24:20]),
        .writeAddr(instrCode[11:7]),
        .writeData(wbData),
        .readData1(rfData1),
        .readData2(rfData2)
    );

    Alu alu0 (
        .aluControl(aluControl),
        .a         (rfData1),
        .b         (aluSrcB),
        .result    (aluResult)
    );

    ImmExtend immExtend0 (
        .instrCode(instrCode),
        .immExt   (immExt)
    );

endmodule

`default_nettype wire

//--- ControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ControlUnit import rvPkg::*; (
    input  logic            reset,
    input  logic [XLEN-1:0] instrCode,
    output logic            regFileWe,
    output logic            aluSrcMuxSel,
    output aluOp            aluControl,
    output wbSel            memToRegSel,
    output pcSel            nextPcSel,
    output logic            busWe
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       regWrite; // Enables before the reset gate.
    logic       memWrite;
    logic       isShift;

    assign opcode   = instrCode[6:0];
    assign funct3   = instrCode[14:12];
    assign funct7b5 = instrCode[30];
    assign isShift  = (funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRX);

    always_comb begin
        regWrite     = 1'b0;
        memWrite     = 1'b0;
        aluSrcMuxSel = 1'b0;
        aluControl   = ADD;
        memToRegSel  = WB_ALU;
        nextPcSel    = PC_SEQ;
        case (opcode)
            OP_TYPE_R: begin
                regWrite   = 1'b1;
                aluControl = aluOp'({funct7b5, funct3});
            end
            OP_TYPE_I: begin
                regWrite     = 1'b1;
                aluSrcMuxSel = 1'b1;
                // Bit 30 is part of the immediate except on shifts.
                aluControl   = aluOp'({funct7b5 & isShift, funct3});
            end
            OP_TYPE_I_LOAD: begin
                regWrite     = 1'b1;
                aluSrcMuxSel = 1'b1;
                memToRegSel  = WB_LOAD;
            end
            OP_TYPE_S: begin
                memWrite     = 1'b1;
                aluSrcMuxSel = 1'b1; // Address is base plus offset.
            end
            OP_TYPE_U_LUI: begin
                regWrite     = 1'b1;
                aluSrcMuxSel = 1'b1;
                memToRegSel  = WB_IMM;
            end
            OP_TYPE_J_JAL: begin
                regWrite    = 1'b1;
                memToRegSel = WB_PC4;
                nextPcSel   = PC_JUMP;
            end
            default: begin
                regWrite = 1'b0; // Unknown opcodes change no state.
            end
        endcase
    end

    assign regFileWe = regWrite & ~reset;
    assign busWe     = memWrite & ~reset;

endmodule

`default_nettype wire

//--- ImmExtend.sv
`timescale 1ns/1ps
`default_nettype none

module ImmExtend import rvPkg::*; (
    input  logic [XLEN-1:0] instrCode,
    output logic [XLEN-1:0] immExt
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       signBit;

    assign opcode  = instrCode[6:0];
    assign funct3  = instrCode[14:12];
    assign signBit = instrCode[31];

    always_comb begin
        case (opcode)
            OP_TYPE_I: begin
                if (funct3 == FUNCT3_SLL || funct3 == FUNCT3_SRX) begin
                    immExt = {27'b0, instrCode[24:20]}; // Shift amount, unsigned.
                end else begin
                    immExt = {{20{signBit}}, instrCode[31:20]};
                end
            end
            OP_TYPE_I_LOAD: begin
                immExt = {{20{signBit}}, instrCode[31:20]};
            end
            OP_TYPE_S: begin
                immExt = {{20{signBit}}, instrCode[31:25], instrCode[11:7]};
            end
            OP_TYPE_U_LUI: begin
                immExt = {instrCode[31:12], 12'b0};
            end
            OP_TYPE_J_JAL: begin
                // J format scatters the offset, bit 0 is implied zero.
                immExt = {{12{signBit}}, instrCode[19:12], instrCode[20],
                          instrCode[30:21], 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu import rvPkg::*; (
    input  aluOp            aluControl,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);
    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only the low five bits shift.

    always_comb begin
        case (aluControl)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLT: begin
                result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            end
            SLTU: begin
                result = (a < b) ? XLEN'(1) : '0;
            end
            XOR:     result = a ^ b;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0; // Unused encodings.
        endcase
    end

endmodule

`default_nettype wire

//--- RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile import rvPkg::*; #(
    parameter int numRegs = 32
) (
    input  logic            clk,
    input  logic            we,
    input  logic [4:0]      readAddr1,
    input  logic [4:0]      readAddr2,
    input  logic [4:0]      writeAddr,
    input  logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData1,
    output logic [XLEN-1:0] readData2
);
    localparam int idxWidth = $clog2(numRegs);

    logic [XLEN-1:0]     regs [numRegs];
    logic [idxWidth-1:0] readIdx1;
    logic [idxWidth-1:0] readIdx2;
    logic [idxWidth-1:0] writeIdx;

    // Indices beyond the file wrap around.
    assign readIdx1 = idxWidth'(readAddr1 % numRegs);
    assign readIdx2 = idxWidth'(readAddr2 % numRegs);
    assign writeIdx = idxWidth'(writeAddr % numRegs);

    initial begin
        for (int i = 0; i < numRegs; i++) begin
            regs[i] = XLEN'(i); // Power-up value is the index.
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readData1 = (readIdx1 != '0) ? regs[readIdx1] : '0; // x0 reads zero.
    assign readData2 = (readIdx2 != '0) ? regs[readIdx2] : '0;

endmodule

`default_nettype wire

//--- rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OP_TYPE_R      = 7'b0110011,
        OP_TYPE_I      = 7'b0010011,
        OP_TYPE_I_LOAD = 7'b0000011,
        OP_TYPE_S      = 7'b0100011,
        OP_TYPE_U_LUI  = 7'b0110111,
        OP_TYPE_J_JAL  = 7'b1101111
    } opType;

    localparam logic [2:0] FUNCT3_SLL = 3'b001; // SLL and SLLI.
    localparam logic [2:0] FUNCT3_SRX = 3'b101; // SRL, SRA and their immediates.

    // Encoded as {funct7[5], funct3}.
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOp;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_LOAD = 2'b01,
        WB_PC4  = 2'b10,
        WB_IMM  = 2'b11
    } wbSel;

    typedef enum logic {
        PC_SEQ  = 1'b0,
        PC_JUMP = 1'b1
    } pcSel;

endpackage

`default_nettype wire
